// File: Bender.yml
package:
  name: grid_capture

dependencies: {}

sources:
  # package first, then the RTL in dependency order
  - hw/grid_pkg.sv
  - hw/sync_fifo.sv
  - hw/sample_id_stamper.sv
  - hw/grid_subscriber.sv
  - hw/grid_capture_top.sv

  - target: test
    files:
      - verification/tb_grid_capture.sv

// File: compile.f
hw/grid_pkg.sv
hw/sync_fifo.sv
hw/sample_id_stamper.sv
hw/grid_subscriber.sv
hw/grid_capture_top.sv
verification/tb_grid_capture.sv

// File: hw/grid_capture_top.sv
// input has no ready and the output ignores back-pressure; only the block exponent is taken from the user word
`default_nettype none
`timescale 1ns/10ps

module grid_capture_top import grid_pkg::*; (
    input  wire logic                  clk_i,
    input  wire logic                  reset_ni,

    // resource grid from the FFT demodulator
    input  wire logic [IQ_WIDTH-1:0]   s_iq_data_i,
    input  wire logic                  s_iq_valid_i,
    input  wire logic                  s_iq_last_i,
    input  wire logic [USER_WIDTH-1:0] s_iq_user_i,

    // stream to the DMA
    input  wire logic                  m_ready_i,
    output logic      [IQ_WIDTH-1:0]   m_data_o,
    output logic                       m_valid_o,

    // status
    output logic                       overflow_o,
    output logic                       int_o
);

    // sample-id queue
    logic [SAMPLE_ID_WIDTH-1:0] id_wr_data;
    logic                       id_wr_en;
    logic [SAMPLE_ID_WIDTH-1:0] id_rd_data;
    logic                       id_rd_valid;
    logic                       id_rd_en;

    // IQ queue, entry is {block exponent, last, iq}
    logic [IQ_FIFO_WIDTH-1:0]   iq_rd_data;
    logic                       iq_rd_valid;
    logic                       iq_rd_en;

    sample_id_stamper u_stamper (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .iq_valid_i (s_iq_valid_i),
        .iq_last_i  (s_iq_last_i),
        .id_data_o  (id_wr_data),
        .id_valid_o (id_wr_en)
    );

    sync_fifo #(
        .DATA_W (SAMPLE_ID_WIDTH),
        .DEPTH  (ID_FIFO_DEPTH)
    ) u_id_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_data_i  (id_wr_data),
        .wr_en_i    (id_wr_en),
        .rd_en_i    (id_rd_en),
        .rd_data_o  (id_rd_data),
        .rd_valid_o (id_rd_valid),
        .full_o     ()
    );

    sync_fifo #(
        .DATA_W (IQ_FIFO_WIDTH),
        .DEPTH  (IQ_FIFO_DEPTH)
    ) u_iq_fifo (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .wr_data_i  ({s_iq_user_i[BLK_EXP_LSB +: BLK_EXP_LEN], s_iq_last_i, s_iq_data_i}),
        .wr_en_i    (s_iq_valid_i),
        .rd_en_i    (iq_rd_en),
        .rd_data_o  (iq_rd_data),
        .rd_valid_o (iq_rd_valid),
        .full_o     ()
    );

    grid_subscriber u_subscriber (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .iq_data_i  (iq_rd_data[IQ_WIDTH-1:0]),
        .iq_last_i  (iq_rd_data[IQ_WIDTH]),
        .blk_exp_i  (iq_rd_data[IQ_WIDTH+1 +: BLK_EXP_LEN]),
        .iq_valid_i (iq_rd_valid),
        .id_data_i  (id_rd_data),
        .id_valid_i (id_rd_valid),
        .m_ready_i  (m_ready_i),
        .iq_rd_en_o (iq_rd_en),
        .id_rd_en_o (id_rd_en),
        .m_data_o   (m_data_o),
        .m_valid_o  (m_valid_o),
        .overflow_o (overflow_o),
        .int_o      (int_o)
    );

endmodule

`default_nettype wire

// File: hw/grid_pkg.sv
// widths and field offsets are fixed at these values and the RTL assumes IQ_WIDTH divides SAMPLE_ID_WIDTH
`default_nettype none

package grid_pkg;

    // sample and output word
    localparam int IQ_WIDTH = 16;
    localparam int BLK_EXP_LEN = 8;

    // user word field widths
    localparam int SFN_WIDTH = 10;
    localparam int SUBFRAME_NUMBER_WIDTH = 5;
    localparam int SYMBOL_NUMBER_WIDTH = 4;

    // user word layout from bit 0 upward
    // spare bit, block exponent, symbol, subframe, system frame number
    localparam int BLK_EXP_LSB = 1;
    localparam int SYMBOL_LSB = BLK_EXP_LSB + BLK_EXP_LEN;
    localparam int SUBFRAME_LSB = SYMBOL_LSB + SYMBOL_NUMBER_WIDTH;
    localparam int SFN_LSB = SUBFRAME_LSB + SUBFRAME_NUMBER_WIDTH;
    localparam int USER_WIDTH = SFN_LSB + SFN_WIDTH;

    // sample index, sent as several output words
    localparam int SAMPLE_ID_WIDTH = 64;
    localparam int NUM_TIMESTAMP_WORDS = SAMPLE_ID_WIDTH / IQ_WIDTH;
    localparam int TS_CNT_WIDTH = $clog2(NUM_TIMESTAMP_WORDS);

    // IQ FIFO entry holds {block exponent, last, iq}
    localparam int IQ_FIFO_WIDTH = BLK_EXP_LEN + 1 + IQ_WIDTH;

    // FIFO depths
    localparam int IQ_FIFO_DEPTH = 1024;
    localparam int ID_FIFO_DEPTH = 16;

    // subscriber FSM encoding
    localparam int STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_WIDTH-1:0] ST_TS_START = 2'd1;
    localparam logic [STATE_WIDTH-1:0] ST_TS_SHIFT = 2'd2;
    localparam logic [STATE_WIDTH-1:0] ST_FORWARD = 2'd3;

endpackage

`default_nettype wire

// File: hw/grid_subscriber.sv
// output ignores m_ready_i apart from reporting overflow; a symbol's sample index must reach its FIFO
`default_nettype none
`timescale 1ns/10ps

module grid_subscriber import grid_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       reset_ni,

    // head of the IQ FIFO
    input  wire logic [IQ_WIDTH-1:0]        iq_data_i,
    input  wire logic                       iq_last_i,
    input  wire logic [BLK_EXP_LEN-1:0]     blk_exp_i,
    input  wire logic                       iq_valid_i,

    // head of the sample-id FIFO
    input  wire logic [SAMPLE_ID_WIDTH-1:0] id_data_i,
    input  wire logic                       id_valid_i,

    // ready from the DMA
    input  wire logic                       m_ready_i,

    // FIFO read enables
    output logic                            iq_rd_en_o,
    output logic                            id_rd_en_o,

    // stream to the DMA
    output logic      [IQ_WIDTH-1:0]        m_data_o,
    output logic                            m_valid_o,

    // status
    output logic                            overflow_o,
    output logic                            int_o
);

    logic [STATE_WIDTH-1:0]     state_q;
    logic [SAMPLE_ID_WIDTH-1:0] id_buf_q;
    logic [TS_CNT_WIDTH-1:0]    word_cnt_q;

    // last IQ word of the symbol leaves the FIFO this cycle
    logic last_pop;
    // delays the interrupt until the cycle after that word is shown
    logic int_pend_q;

    assign last_pop = (state_q == ST_FORWARD) && iq_rd_en_o && iq_valid_i && iq_last_i;

    // control path
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_IDLE;
            word_cnt_q <= '0;
            m_valid_o <= 1'b0;
            iq_rd_en_o <= 1'b0;
            id_rd_en_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // a symbol has reached the IQ FIFO, so send its block exponent
                    m_valid_o <= iq_valid_i;
                    if (iq_valid_i) begin
                        state_q <= ST_TS_START;
                    end
                end
                ST_TS_START: begin
                    // low timestamp word goes out straight from the FIFO head
                    m_valid_o <= id_valid_i;
                    if (id_valid_i) begin
                        id_rd_en_o <= 1'b1;
                        word_cnt_q <= TS_CNT_WIDTH'(1);
                        state_q <= ST_TS_SHIFT;
                    end
                end
                ST_TS_SHIFT: begin
                    id_rd_en_o <= 1'b0;
                    m_valid_o <= 1'b1;
                    if (word_cnt_q == TS_CNT_WIDTH'(NUM_TIMESTAMP_WORDS - 1)) begin
                        iq_rd_en_o <= 1'b1;
                        state_q <= ST_FORWARD;
                    end else begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                    end
                end
                ST_FORWARD: begin
                    // empty FIFO shows up as a gap on the output
                    m_valid_o <= iq_valid_i;
                    if (last_pop) begin
                        iq_rd_en_o <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // data path
    always_ff @(posedge clk_i) begin
        case (state_q)
            ST_IDLE: begin
                m_data_o <= {{(IQ_WIDTH - BLK_EXP_LEN){1'b0}}, blk_exp_i};
            end
            ST_TS_START: begin
                m_data_o <= id_data_i[IQ_WIDTH-1:0];
                id_buf_q <= id_data_i >> IQ_WIDTH;
            end
            ST_TS_SHIFT: begin
                m_data_o <= id_buf_q[IQ_WIDTH-1:0];
                id_buf_q <= id_buf_q >> IQ_WIDTH;
            end
            default: begin
                m_data_o <= iq_data_i;
            end
        endcase
    end

    // status
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow_o <= 1'b0;
            int_pend_q <= 1'b0;
            int_o <= 1'b0;
        end else begin
            // beat offered but not taken by the DMA
            overflow_o <= m_valid_o && !m_ready_i;
            int_pend_q <= last_pop;
            int_o <= int_pend_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_id_stamper.sv
// counts every input beat from zero after reset; the 64-bit counter is assumed never to wrap
`default_nettype none
`timescale 1ns/10ps

module sample_id_stamper import grid_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       reset_ni,

    // input strobe, observed only
    input  wire logic                       iq_valid_i,
    input  wire logic                       iq_last_i,

    // write port of the sample-id FIFO
    output logic      [SAMPLE_ID_WIDTH-1:0] id_data_o,
    output logic                            id_valid_o
);

    logic [SAMPLE_ID_WIDTH-1:0] count_q;
    // next beat opens a symbol
    logic                       start_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            count_q <= '0;
            start_q <= 1'b1;
            id_valid_o <= 1'b0;
        end else begin
            // one FIFO write per symbol start
            id_valid_o <= iq_valid_i && start_q;
            if (iq_valid_i) begin
                count_q <= count_q + 1'b1;
                start_q <= iq_last_i;
            end
        end
    end

    // pre-increment count, i.e. beats seen before this symbol
    always_ff @(posedge clk_i) begin
        if (iq_valid_i && start_q) begin
            id_data_o <= count_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
// single clock first-word-fall-through FIFO; DEPTH must be at least 2 and writes when full are dropped
`default_nettype none
`timescale 1ns/10ps

module sync_fifo #(
    parameter int DATA_W = 16,
    parameter int DEPTH = 16
) (
    input  wire logic              clk_i,
    input  wire logic              reset_ni,

    // write side
    input  wire logic [DATA_W-1:0] wr_data_i,
    input  wire logic              wr_en_i,

    // read side
    input  wire logic              rd_en_i,
    output logic      [DATA_W-1:0] rd_data_o,
    output logic                   rd_valid_o,

    output logic                   full_o
);

    logic [DATA_W-1:0] mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    logic wr_ok;
    logic rd_ok;

    // head word is shown as soon as the count is non-zero
    assign rd_valid_o = (count_q != '0);
    assign full_o = (count_q == DEPTH);
    assign rd_data_o = mem[rd_ptr_q];

    assign wr_ok = wr_en_i && !full_o;
    assign rd_ok = rd_en_i && rd_valid_o;

    // storage
    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    // pointers wrap explicitly so the depth need not be a power of two
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_ok) begin
                if (wr_ptr_q == DEPTH - 1) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (rd_ok) begin
                if (rd_ptr_q == DEPTH - 1) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
        end
    end

    // occupancy
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            count_q <= '0;
        end else begin
            case ({wr_ok, rd_ok})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                    // simultaneous write and read keeps the count
                    count_q <= count_q;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_grid_capture.sv
// random symbols with gaps into grid_capture_top; assumes neither FIFO fills and that m_ready_i only drives overflow_o
`default_nettype none
`timescale 1ns/10ps

module tb_grid_capture import grid_pkg::*; ();

    localparam int NUM_SYMBOLS = 20;
    localparam int MIN_LEN = 4;
    localparam int MAX_LEN = 40;
    localparam int WAIT_LIMIT = 2000;

    logic                  clk_i;
    logic                  reset_ni;
    logic [IQ_WIDTH-1:0]   s_iq_data_i;
    logic                  s_iq_valid_i;
    logic                  s_iq_last_i;
    logic [USER_WIDTH-1:0] s_iq_user_i;
    logic                  m_ready_i;
    logic [IQ_WIDTH-1:0]   m_data_o;
    logic                  m_valid_o;
    logic                  overflow_o;
    logic                  int_o;

    integer seed;

    // expected output words and whether each one closes a symbol
    logic [IQ_WIDTH-1:0]        exp_words [$];
    logic                       exp_last [$];
    logic [SAMPLE_ID_WIDTH-1:0] beats_sent;
    logic                       ready_noise;
    logic                       last_shown;
    logic                       released;
    int                         int_count;
    int                         reset_edges;

    grid_capture_top u_grid_capture_top (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .s_iq_data_i  (s_iq_data_i),
        .s_iq_valid_i (s_iq_valid_i),
        .s_iq_last_i  (s_iq_last_i),
        .s_iq_user_i  (s_iq_user_i),
        .m_ready_i    (m_ready_i),
        .m_data_o     (m_data_o),
        .m_valid_o    (m_valid_o),
        .overflow_o   (overflow_o),
        .int_o        (int_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timeout_error(input string msg);
        $display("Gave up after %0d cycles waiting for %s", WAIT_LIMIT, msg);
        stop_with_failure();
    endtask

    function automatic int pick(input int lo, input int hi);
        logic [31:0] rnd;
        rnd = $random(seed);
        return lo + int'(rnd % (hi - lo + 1));
    endfunction

    // advances one rising edge and randomizes ready inside the noise window
    task automatic next_edge();
        logic [31:0] rnd;
        @(posedge clk_i);
        rnd = $random(seed);
        m_ready_i <= ready_noise ? rnd[0] : 1'b1;
    endtask

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            next_edge();
            s_iq_valid_i <= 1'b0;
            s_iq_last_i <= 1'b0;
        end
    endtask

    task automatic drive_beat(input logic [IQ_WIDTH-1:0] data, input logic last,
                              input logic [USER_WIDTH-1:0] user);
        next_edge();
        s_iq_valid_i <= 1'b1;
        s_iq_data_i <= data;
        s_iq_last_i <= last;
        s_iq_user_i <= user;
        beats_sent = beats_sent + 1;
    endtask

    task automatic send_symbol(input int len);
        logic [31:0]            rnd;
        logic [USER_WIDTH-1:0]  user;
        logic [IQ_WIDTH-1:0]    data;
        logic [BLK_EXP_LEN-1:0] blk_exp;

        rnd = $random(seed);
        blk_exp = rnd[BLK_EXP_LEN-1:0];
        user = '0;
        user[0] = rnd[31];
        user[BLK_EXP_LSB +: BLK_EXP_LEN] = blk_exp;
        user[SYMBOL_LSB +: SYMBOL_NUMBER_WIDTH] = rnd[8 +: SYMBOL_NUMBER_WIDTH];
        user[SUBFRAME_LSB +: SUBFRAME_NUMBER_WIDTH] = rnd[12 +: SUBFRAME_NUMBER_WIDTH];
        user[SFN_LSB +: SFN_WIDTH] = rnd[17 +: SFN_WIDTH];

        // header holds the exponent and then the count of earlier beats from the low word up
        exp_words.push_back(IQ_WIDTH'(blk_exp));
        exp_last.push_back(1'b0);
        for (int k = 0; k < NUM_TIMESTAMP_WORDS; k++) begin
            exp_words.push_back(beats_sent[k*IQ_WIDTH +: IQ_WIDTH]);
            exp_last.push_back(1'b0);
        end

        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            data = rnd[IQ_WIDTH-1:0];
            exp_words.push_back(data);
            exp_last.push_back(i == len - 1);
            drive_beat(data, i == len - 1, user);
            // occasional hole inside the symbol
            if (rnd[19:18] == 2'b00) begin
                drive_idle(1 + int'(rnd[21:20]));
            end
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_words.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                timeout_error("the output stream to drain");
            end else begin
                drive_idle(1);
                waited++;
            end
        end
    endtask

    task automatic wait_for_interrupts();
        int waited;
        waited = 0;
        while (int_count < NUM_SYMBOLS) begin
            if (waited == WAIT_LIMIT) begin
                timeout_error("the end-of-symbol interrupts");
            end else begin
                drive_idle(1);
                waited++;
            end
        end
    endtask

    // output words and interrupt pulses against the model
    always @(posedge clk_i) begin : monitor
        logic [IQ_WIDTH-1:0] want;
        logic                want_last;
        if (!reset_ni) begin
            if (reset_edges > 0) begin
                assert (!m_valid_o && !overflow_o && !int_o)
                    else value_error("status or valid output high during reset");
            end
            reset_edges++;
            last_shown = 1'b0;
        end else begin
            if (!released) begin
                assert (!m_valid_o && !overflow_o && !int_o)
                    else value_error("status or valid output high right after reset");
                released = 1'b1;
            end
            assert (int_o === last_shown)
                else value_error($sformatf("int_o is %b, expected %b", int_o, last_shown));
            if (int_o) begin
                int_count++;
            end
            last_shown = 1'b0;
            if (m_valid_o) begin
                assert (exp_words.size() != 0)
                    else value_error("output word while none is expected");
                want = exp_words.pop_front();
                want_last = exp_last.pop_front();
                assert (m_data_o === want)
                    else value_error($sformatf("output word %h, expected %h", m_data_o, want));
                last_shown = want_last;
            end
        end
    end

    // overflow_o follows a refused beat by one cycle and is low otherwise
    overflow_check: assert property (@(posedge clk_i) disable iff (!reset_ni)
        overflow_o == $past(m_valid_o && !m_ready_i))
        else value_error("overflow_o does not follow the previous cycle's refused beat");

    initial begin
        seed = 32'h207f;
        reset_ni = 1'b0;
        s_iq_data_i = '0;
        s_iq_valid_i = 1'b0;
        s_iq_last_i = 1'b0;
        s_iq_user_i = '0;
        m_ready_i = 1'b1;
        beats_sent = '0;
        ready_noise = 1'b0;
        last_shown = 1'b0;
        released = 1'b0;
        int_count = 0;
        reset_edges = 0;

        repeat (4) begin
            @(posedge clk_i);
        end
        reset_ni <= 1'b1;

        for (int s = 0; s < NUM_SYMBOLS; s++) begin
            ready_noise = (s >= 6) && (s < 13);
            send_symbol(pick(MIN_LEN, MAX_LEN));
            drive_idle(pick(0, 5));
        end
        ready_noise = 1'b0;
        drive_idle(1);

        wait_for_drain();
        wait_for_interrupts();
        drive_idle(5);

        if (exp_words.size() == 0 && int_count == NUM_SYMBOLS) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            value_error($sformatf("%0d words left over, %0d interrupts for %0d symbols",
                                  exp_words.size(), int_count, NUM_SYMBOLS));
        end
    end

endmodule

`default_nettype wire
